//--- rtl/rat_cfg_pkg.sv
package rat_cfg_pkg;

  // architectural vector registers tracked by the table
  localparam int ARCH_REGS = 16;
  localparam int ARCH_W = 4;

  // port counts per rename group
  localparam int READ_PORTS = 3;
  localparam int RENAME_SLOTS = 3;
  localparam int RETIRE_PORTS = 3;

  // rename tag and functional-unit code widths
  localparam int TAG_W = 9;
  localparam int FU_W = 10;

  // values an entry holds out of reset
  localparam logic [TAG_W-1:0] RESET_TAG = '0;

  // only the top bit set, no unit assigned yet
  localparam logic [FU_W-1:0] RESET_FU = {1'b1, {(FU_W-1){1'b0}}};

endpackage

//--- rtl/rat_types_pkg.sv
package rat_types_pkg;

  import rat_cfg_pkg::*;

  // register file a value lives in
  typedef enum logic [1:0] {
    DOM_INT       = 2'd0,
    DOM_FP_SINGLE = 2'd1,
    DOM_FP_DOUBLE = 2'd2,
    DOM_VEC       = 2'd3
  } reg_domain_t;

  // group set means index is a rename slot of the current group
  typedef struct packed {
    logic              group;
    logic [ARCH_W-1:0] index;
  } rat_addr_t;

  typedef struct packed {
    logic [ARCH_W-1:0] arch;
    logic [TAG_W-1:0]  tag;
    logic [FU_W-1:0]   fu;
    reg_domain_t       dom;
    logic              wen;
  } rename_slot_t;

  // tag match retires an entry, arch names the committed domain to record
  typedef struct packed {
    logic [TAG_W-1:0]  tag;
    logic [ARCH_W-1:0] arch;
    reg_domain_t       dom;
    logic              wen;
  } retire_port_t;

  typedef struct packed {
    logic [TAG_W-1:0] tag;
    logic [FU_W-1:0]  fu;
    reg_domain_t      dom;
    logic             retired;
    logic             is_dep;
  } rat_read_t;

endpackage

//--- rtl/rat_entry.sv
`timescale 1ns/1ps

module rat_entry
  import rat_cfg_pkg::*;
  import rat_types_pkg::*;
#(
  parameter int INDEX = 0
)
(
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             rename_en,
  input  rename_slot_t [RENAME_SLOTS-1:0]  slots,
  input  retire_port_t [RETIRE_PORTS-1:0]  retires,
  input  logic                             flush,
  output rat_read_t                        value
);

  logic [TAG_W-1:0] tag_q;
  logic [FU_W-1:0]  fu_q;
  reg_domain_t      dom_q;
  reg_domain_t      dom_commit_q;
  logic             retired_q;

  logic             ren_hit;
  rename_slot_t     ren_sel;
  logic             ren_write;
  logic             ret_hit;
  logic             commit_hit;
  reg_domain_t      commit_dom;

  always_comb
  begin
    ren_hit = 1'b0;
    ren_sel = '0;
    // later slots override earlier ones naming the same register
    for (int s = 0; s < RENAME_SLOTS; s++)
    begin
      if (slots[s].wen && slots[s].arch == ARCH_W'(INDEX))
      begin
        ren_hit = 1'b1;
        ren_sel = slots[s];
      end
    end
  end

  always_comb
  begin
    ret_hit = 1'b0;
    commit_hit = 1'b0;
    commit_dom = DOM_INT;
    for (int p = 0; p < RETIRE_PORTS; p++)
    begin
      if (retires[p].wen && retires[p].tag == tag_q)
        ret_hit = 1'b1;
      if (retires[p].wen && retires[p].arch == ARCH_W'(INDEX))
      begin
        commit_hit = 1'b1;
        commit_dom = retires[p].dom;
      end
    end
  end

  assign ren_write = rename_en & ren_hit & ~flush;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      tag_q <= RESET_TAG;
      fu_q <= RESET_FU;
      dom_q <= DOM_INT;
      dom_commit_q <= DOM_INT;
      retired_q <= 1'b1;
    end
    else
    begin
      // flush restores the committed view, a new producer beats retirement
      if (flush)
      begin
        retired_q <= 1'b1;
        dom_q <= dom_commit_q;
      end
      else if (ren_write)
      begin
        tag_q <= ren_sel.tag;
        fu_q <= ren_sel.fu;
        dom_q <= ren_sel.dom;
        retired_q <= 1'b0;
      end
      else if (ret_hit)
        retired_q <= 1'b1;
      if (commit_hit)
        dom_commit_q <= commit_dom;
    end
  end

  assign value = '{tag: tag_q, fu: fu_q, dom: dom_q, retired: retired_q, is_dep: 1'b0};

endmodule

//--- rtl/rat_table.sv
`timescale 1ns/1ps

module rat_table
  import rat_cfg_pkg::*;
  import rat_types_pkg::*;
(
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             rename_en,
  input  rename_slot_t [RENAME_SLOTS-1:0]  slots,
  input  retire_port_t [RETIRE_PORTS-1:0]  retires,
  input  logic                             flush,
  input  rat_addr_t    [READ_PORTS-1:0]    lat_addr,
  output rat_read_t    [READ_PORTS-1:0]    entry_out
);

  rat_read_t [ARCH_REGS-1:0] entry_val;

  genvar i;
  genvar p;

  generate
    for (i = 0; i < ARCH_REGS; i++)
    begin : entry_gen
      rat_entry #(
        .INDEX(i)
      ) entry_i (
        .clk(clk),
        .rst(rst),
        .rename_en(rename_en),
        .slots(slots),
        .retires(retires),
        .flush(flush),
        .value(entry_val[i])
      );
    end

    // group reads fall back to entry 0 when the slot number is out of range
    for (p = 0; p < READ_PORTS; p++)
    begin : port_gen
      assign entry_out[p] = lat_addr[p].group ? entry_val[0] : entry_val[lat_addr[p].index];
    end
  endgenerate

endmodule

//--- rtl/rat_read_latch.sv
`timescale 1ns/1ps

module rat_read_latch
  import rat_cfg_pkg::*;
  import rat_types_pkg::*;
(
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          rename_en,
  input  rat_addr_t [READ_PORTS-1:0]    read_addr,
  output rat_addr_t [READ_PORTS-1:0]    lat_addr
);

  // addresses advance with the rename stage and hold while it stalls
  always_ff @(posedge clk)
  begin
    if (rst)
      lat_addr <= '0;
    else if (rename_en)
      lat_addr <= read_addr;
  end

endmodule

//--- rtl/rat_dep_bypass.sv
`timescale 1ns/1ps

module rat_dep_bypass
  import rat_cfg_pkg::*;
  import rat_types_pkg::*;
(
  input  rat_addr_t    [READ_PORTS-1:0]    lat_addr,
  input  rat_read_t    [READ_PORTS-1:0]    entry_out,
  input  rename_slot_t [RENAME_SLOTS-1:0]  slots,
  output rat_read_t    [READ_PORTS-1:0]    read_out
);

  always_comb
  begin
    for (int p = 0; p < READ_PORTS; p++)
    begin
      read_out[p] = entry_out[p];
      if (lat_addr[p].group)
      begin
        // producer still in the current rename group, not in the table yet
        for (int s = 0; s < RENAME_SLOTS; s++)
        begin
          if (lat_addr[p].index == ARCH_W'(s))
          begin
            read_out[p].tag = slots[s].tag;
            read_out[p].fu = slots[s].fu;
            read_out[p].dom = slots[s].dom;
            read_out[p].retired = 1'b0;
            read_out[p].is_dep = 1'b1;
          end
        end
      end
    end
  end

endmodule

//--- rtl/vec_rat.sv
`timescale 1ns/1ps

module vec_rat
  import rat_cfg_pkg::*;
  import rat_types_pkg::*;
(
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             rename_en,
  input  rat_addr_t    [READ_PORTS-1:0]    read_addr,
  input  rename_slot_t [RENAME_SLOTS-1:0]  slots,
  input  retire_port_t [RETIRE_PORTS-1:0]  retires,
  input  logic                             flush,
  output rat_read_t    [READ_PORTS-1:0]    read_out
);

  rat_addr_t [READ_PORTS-1:0] lat_addr;
  rat_read_t [READ_PORTS-1:0] entry_out;

  rat_read_latch latch_i (
    .clk(clk),
    .rst(rst),
    .rename_en(rename_en),
    .read_addr(read_addr),
    .lat_addr(lat_addr)
  );

  rat_table table_i (
    .clk(clk),
    .rst(rst),
    .rename_en(rename_en),
    .slots(slots),
    .retires(retires),
    .flush(flush),
    .lat_addr(lat_addr),
    .entry_out(entry_out)
  );

  rat_dep_bypass bypass_i (
    .lat_addr(lat_addr),
    .entry_out(entry_out),
    .slots(slots),
    .read_out(read_out)
  );

endmodule

//--- testbench/vec_rat_tb.sv
`timescale 1ns/1ps

module vec_rat_tb
  import rat_cfg_pkg::*;
  import rat_types_pkg::*;
();

  localparam int MAX_TESTS = 64;

  // one record of the test file
  typedef struct packed {
    logic              en;
    logic              join_next;
    logic [1:0]        idx;
    logic [ARCH_W-1:0] arch;
    logic [TAG_W-1:0]  tag;
    logic [FU_W-1:0]   fu;
    reg_domain_t       dom;
    logic              grp;
    rat_read_t         expected;
  } test_rec_t;

  logic                            clk;
  logic                            rst;
  logic                            rename_en;
  rat_addr_t    [READ_PORTS-1:0]   read_addr;
  rename_slot_t [RENAME_SLOTS-1:0] slots;
  retire_port_t [RETIRE_PORTS-1:0] retires;
  logic                            flush;
  rat_read_t    [READ_PORTS-1:0]   read_out;

  string     cmd_tab [MAX_TESTS];
  test_rec_t rec_tab [MAX_TESTS];
  int        num_tests = 0;
  int        limit_cycles = 1000;
  int        cycles = 0;
  int        pass_count = 0;
  int        fail_count = 0;

  // values collected for the cycle being driven
  logic                            cyc_en;
  logic                            cyc_flush;
  rename_slot_t [RENAME_SLOTS-1:0] cyc_slots;
  retire_port_t [RETIRE_PORTS-1:0] cyc_retires;
  rat_addr_t    [READ_PORTS-1:0]   cur_addr;

  int next_line;
  int first_line;
  int last_line;
  int prev_first;
  int prev_last;
  logic have_prev;

  vec_rat dut_i (
    .clk(clk),
    .rst(rst),
    .rename_en(rename_en),
    .read_addr(read_addr),
    .slots(slots),
    .retires(retires),
    .flush(flush),
    .read_out(read_out)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (cycles > limit_cycles)
    begin
      $display("timeout: test sequence did not finish within %0d cycles", limit_cycles);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  task automatic load_tests();
    int fd;
    int code;
    string line;
    string cmd;
    int en_v, jn_v, idx_v, arch_v, tag_v, fu_v, dom_v, grp_v;
    int etag_v, efu_v, edom_v, eret_v, edep_v;
    test_rec_t r;
    fd = $fopen("testbench/vec_rat_tests.txt", "r");
    if (fd == 0)
    begin
      $display("could not open the test file testbench/vec_rat_tests.txt");
      return;
    end
    while (!$feof(fd) && num_tests < MAX_TESTS)
    begin
      line = "";
      code = $fgets(line, fd);
      // skip comments and blank lines
      if (line.len() < 2 || line.getc(0) == 8'h23)
        continue;
      code = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h", cmd,
                     en_v, jn_v, idx_v, arch_v, tag_v, fu_v, dom_v, grp_v,
                     etag_v, efu_v, edom_v, eret_v, edep_v);
      if (code != 14 || !(cmd == "rename" || cmd == "retire" || cmd == "flush" ||
                          cmd == "read" || cmd == "idle"))
      begin
        $display("malformed line in test file: %s", line);
        fail_count++;
        continue;
      end
      r.en = en_v[0];
      r.join_next = jn_v[0];
      r.idx = idx_v[1:0];
      r.arch = arch_v[ARCH_W-1:0];
      r.tag = tag_v[TAG_W-1:0];
      r.fu = fu_v[FU_W-1:0];
      r.dom = reg_domain_t'(dom_v[1:0]);
      r.grp = grp_v[0];
      r.expected.tag = etag_v[TAG_W-1:0];
      r.expected.fu = efu_v[FU_W-1:0];
      r.expected.dom = reg_domain_t'(edom_v[1:0]);
      r.expected.retired = eret_v[0];
      r.expected.is_dep = edep_v[0];
      cmd_tab[num_tests] = cmd;
      rec_tab[num_tests] = r;
      num_tests++;
    end
    $fclose(fd);
  endtask

  task automatic clear_cycle();
    cyc_en = 1'b0;
    cyc_flush = 1'b0;
    cyc_slots = '0;
    cyc_retires = '0;
  endtask

  task automatic add_line(input int j);
    test_rec_t r;
    r = rec_tab[j];
    if (r.en)
      cyc_en = 1'b1;
    if (cmd_tab[j] == "rename")
      cyc_slots[r.idx] = '{arch: r.arch, tag: r.tag, fu: r.fu, dom: r.dom, wen: 1'b1};
    else if (cmd_tab[j] == "retire")
      cyc_retires[r.idx] = '{tag: r.tag, arch: r.arch, dom: r.dom, wen: 1'b1};
    else if (cmd_tab[j] == "flush")
      cyc_flush = 1'b1;
    else if (cmd_tab[j] == "read")
      cur_addr[r.idx] = '{group: r.grp, index: r.arch};
  endtask

  task automatic drive_cycle();
    @(posedge clk);
    rename_en <= cyc_en;
    flush <= cyc_flush;
    slots <= cyc_slots;
    retires <= cyc_retires;
    read_addr <= cur_addr;
  endtask

  // a read is checked in the cycle after the one that presented its address
  task automatic finish_line(input int j);
    test_rec_t r;
    rat_read_t got;
    int bad;
    r = rec_tab[j];
    bad = 0;
    if (cmd_tab[j] == "read")
    begin
      got = read_out[r.idx];
      assert (got.tag == r.expected.tag)
      else
      begin
        $display("[FAIL] test %0d read_out[%0d].tag expected %h got %h",
                 j + 1, r.idx, r.expected.tag, got.tag);
        bad++;
      end
      assert (got.fu == r.expected.fu)
      else
      begin
        $display("[FAIL] test %0d read_out[%0d].fu expected %h got %h",
                 j + 1, r.idx, r.expected.fu, got.fu);
        bad++;
      end
      assert (got.dom == r.expected.dom)
      else
      begin
        $display("[FAIL] test %0d read_out[%0d].dom expected %h got %h",
                 j + 1, r.idx, r.expected.dom, got.dom);
        bad++;
      end
      assert (got.retired == r.expected.retired)
      else
      begin
        $display("[FAIL] test %0d read_out[%0d].retired expected %h got %h",
                 j + 1, r.idx, r.expected.retired, got.retired);
        bad++;
      end
      assert (got.is_dep == r.expected.is_dep)
      else
      begin
        $display("[FAIL] test %0d read_out[%0d].is_dep expected %h got %h",
                 j + 1, r.idx, r.expected.is_dep, got.is_dep);
        bad++;
      end
    end
    if (bad == 0)
    begin
      pass_count++;
      $display("test %0d %s passed", j + 1, cmd_tab[j]);
    end
    else
    begin
      fail_count++;
      $display("test %0d %s failed", j + 1, cmd_tab[j]);
    end
  endtask

  task automatic finish_prev();
    if (have_prev)
    begin
      for (int j = prev_first; j <= prev_last; j++)
        finish_line(j);
    end
  endtask

  initial
  begin
    rst = 1'b1;
    rename_en = 1'b0;
    read_addr = '0;
    slots = '0;
    retires = '0;
    flush = 1'b0;
    cur_addr = '0;
    have_prev = 1'b0;
    clear_cycle();
    load_tests();
    limit_cycles = 10 * num_tests + 20;
    if (num_tests == 0)
    begin
      $display("no tests were loaded from the test file");
      fail_count++;
    end

    repeat (4) @(posedge clk);
    rst <= 1'b0;

    next_line = 0;
    while (next_line < num_tests)
    begin
      // lines with the join bit set share a cycle with the next line
      first_line = next_line;
      last_line = next_line;
      clear_cycle();
      add_line(last_line);
      while (rec_tab[last_line].join_next && last_line + 1 < num_tests)
      begin
        last_line++;
        add_line(last_line);
      end
      next_line = last_line + 1;
      drive_cycle();
      @(negedge clk);
      finish_prev();
      prev_first = first_line;
      prev_last = last_line;
      have_prev = 1'b1;
    end

    clear_cycle();
    drive_cycle();
    @(negedge clk);
    finish_prev();

    $display("tests: %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

//--- vec_rat.f
rtl/rat_cfg_pkg.sv
rtl/rat_types_pkg.sv
rtl/rat_entry.sv
rtl/rat_table.sv
rtl/rat_read_latch.sv
rtl/rat_dep_bypass.sv
rtl/vec_rat.sv
testbench/vec_rat_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the vec_rat testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module vec_rat_tb -f vec_rat.f -o vec_rat_sim

./obj_dir/vec_rat_sim | tee sim.log

if grep -q "SIMULATION FAILED" sim.log; then
  echo "run_sim: failure reported in sim.log"
  exit 1
fi
echo "run_sim: no failure reported in sim.log"

//--- testbench/vec_rat_tests.txt
# columns: cmd en join idx arch tag fu dom grp, then expected tag fu dom retired is_dep (hex)
# idx is slot, retire port or read port; arch is the read index or slot number of a group read
read   1 0 0 0 000 000 0 0 000 200 0 1 0
read   1 0 2 f 000 000 0 0 000 200 0 1 0
rename 1 0 0 3 011 005 3 0 000 000 0 0 0
read   1 0 1 3 000 000 0 0 011 005 3 0 0
rename 1 1 0 5 021 001 1 0 000 000 0 0 0
rename 1 0 2 5 022 002 2 0 000 000 0 0 0
read   1 0 0 5 000 000 0 0 022 002 2 0 0
retire 0 0 0 3 011 000 3 0 000 000 0 0 0
read   1 0 1 3 000 000 0 0 011 005 3 1 0
retire 0 0 1 5 023 000 2 0 000 000 0 0 0
read   1 0 2 5 000 000 0 0 022 002 2 0 0
retire 1 1 0 5 022 000 1 0 000 000 0 0 0
rename 1 0 1 5 031 004 3 0 000 000 0 0 0
read   1 0 0 5 000 000 0 0 031 004 3 0 0
read   1 0 1 1 000 000 0 1 041 008 2 0 1
rename 0 0 1 7 041 008 2 0 000 000 0 0 0
read   1 0 2 3 000 000 0 1 000 200 0 1 0
read   1 0 0 0 000 000 0 1 051 010 1 0 1
rename 1 0 0 9 051 010 1 0 000 000 0 0 0
read   1 0 0 9 000 000 0 0 051 010 1 0 0
retire 0 0 2 9 051 000 2 0 000 000 0 0 0
rename 1 0 0 3 061 020 1 0 000 000 0 0 0
rename 1 0 2 9 062 040 3 0 000 000 0 0 0
read   1 0 1 3 000 000 0 0 061 020 1 0 0
flush  1 1 0 0 000 000 0 0 000 000 0 0 0
rename 1 0 0 5 071 080 0 0 000 000 0 0 0
read   1 0 0 3 000 000 0 0 061 020 3 1 0
read   1 0 1 5 000 000 0 0 031 004 1 1 0
read   1 0 2 9 000 000 0 0 062 040 2 1 0
read   1 0 0 7 000 000 0 0 000 200 0 1 0
read   0 0 0 5 000 000 0 0 000 200 0 1 0
rename 0 0 2 7 081 100 3 0 000 000 0 0 0
idle   0 0 0 0 000 000 0 0 000 000 0 0 0
read   1 0 0 7 000 000 0 0 000 200 0 1 0
